// ==== hdl/axi_writer_pkg.sv ====
package axi_writer_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  // Byte count width caps a single transfer just under 1 MB
  localparam int size_width = 20;
  // Address bits that select a byte lane within one beat
  localparam int beat_bits  = $clog2(strb_width);

  ////////////////////////////////////////////////////////////////////////////
  // Burst constants
  ////////////////////////////////////////////////////////////////////////////
  // Lesser of the 4 kB boundary rule and the 256 beat protocol limit
  localparam int burst_beats = (4096 / strb_width < 256) ? 4096 / strb_width : 256;
  // Address step between bursts is one 4 kB page
  localparam int burst_bytes = 4096;
  localparam int len_width   = $clog2(burst_beats);
  // Bursts per transfer stored as count minus one
  localparam int txn_width   = size_width - beat_bits - len_width;

  // Start request sampled with ctrl_start
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [size_width-1:0] size;
  } ctrl_req_t;

  // Per-transfer burst plan shared by all channel modules
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [txn_width-1:0]  num_bursts;
    logic [len_width-1:0]  final_len;
    logic [strb_width-1:0] final_strb;
    logic                  single;
  } burst_plan_t;

  // Write address beat
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [len_width-1:0]  len;
  } aw_req_t;

  // Write data beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
  } w_beat_t;

  typedef enum logic {
    w_idle,
    w_run
  } run_state_e;

endpackage

// ==== hdl/xfer_setup.sv ====
`timescale 1ns/1ps

module xfer_setup (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        ctrl_start,
  input  axi_writer_pkg::ctrl_req_t   ctrl_req,
  output logic                        start,
  output axi_writer_pkg::burst_plan_t plan
);

  import axi_writer_pkg::*;

  localparam int total_width = size_width - beat_bits;
  localparam logic [addr_width-1:0] addr_mask = addr_width'(burst_bytes - 1);

  logic                   start_d1;
  // Beats in the transfer minus one, in awlen style
  logic [total_width-1:0] total_len_r;
  logic [addr_width-1:0]  addr_r;
  // Byte remainder minus one, wraps to all lanes for an exact beat count
  logic [beat_bits-1:0]   rem_r;

  //////////////////////////////////////////////////////////////////////////
  // Stage 1, capture the request
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats and subtract one
      if (ctrl_req.size[beat_bits-1:0] != '0) begin
        total_len_r <= ctrl_req.size[size_width-1:beat_bits];
      end else begin
        total_len_r <= ctrl_req.size[size_width-1:beat_bits] - 1'b1;
      end
      // Force the start onto a 4 kB boundary
      addr_r <= ctrl_req.addr & ~addr_mask;
      rem_r  <= ctrl_req.size[beat_bits-1:0] - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stage 2, split into bursts
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    plan.addr       <= addr_r;
    // Upper bits count the full bursts beyond the first
    plan.num_bursts <= total_len_r[total_width-1:len_width];
    plan.final_len  <= total_len_r[len_width-1:0];
    plan.single     <= (total_len_r[total_width-1:len_width] == '0);
    // Lane 0 always carries data on the final beat
    for (int i = 0; i < strb_width; i++) begin
      plan.final_strb[i] <= (i <= int'(rem_r));
    end
  end

  // Start pulse lines up with the plan
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

endmodule

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int fifo_depth = 32
) (
  input  logic                                  aclk,
  input  logic                                  areset,
  input  logic                                  push_valid,
  output logic                                  push_ready,
  input  logic [axi_writer_pkg::data_width-1:0] push_data,
  input  logic                                  pop,
  output logic [axi_writer_pkg::data_width-1:0] head,
  output logic                                  head_valid
);

  import axi_writer_pkg::*;

  localparam int ptr_width = $clog2(fifo_depth);
  localparam int cnt_width = $clog2(fifo_depth + 1);

  logic [data_width-1:0] mem [fifo_depth];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  do_push;
  logic                  do_pop;

  // Almost full leaves room for one word already in flight
  assign push_ready = (count < cnt_width'(fifo_depth - 1));
  assign do_push    = push_valid & push_ready;
  assign do_pop     = pop & head_valid;

  // Fall-through head, visible the cycle after the push
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the fill level alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/w_channel.sv ====
`timescale 1ns/1ps

module w_channel (
  input  logic                                  aclk,
  input  logic                                  areset,
  input  logic                                  start,
  input  axi_writer_pkg::burst_plan_t           plan,
  input  logic [axi_writer_pkg::data_width-1:0] head,
  input  logic                                  head_valid,
  output logic                                  pop,
  output logic                                  wvalid,
  input  logic                                  wready,
  output axi_writer_pkg::w_beat_t               w,
  output logic                                  burst_ready,
  output logic                                  final_burst
);

  import axi_writer_pkg::*;

  run_state_e            state;
  logic                  wxfer;
  logic                  wlast;
  logic                  final_xfer;
  logic                  load_beats;
  logic [len_width-1:0]  beats_left;
  logic [txn_width-1:0]  bursts_left;
  // First-beat tracking for the address channel
  logic                  wfirst;
  logic                  offer_d1;
  logic                  pulse_d1;

  // No beats leave the FIFO until the plan is known
  assign wvalid     = head_valid & (state == w_run);
  assign wxfer      = wvalid & wready;
  assign pop        = wxfer;
  assign final_xfer = wxfer & wlast & final_burst;

  always_ff @(posedge aclk) begin
    if (areset) begin
      state <= w_idle;
    end else begin
      case (state)
        w_idle: begin
          if (start) begin
            state <= w_run;
          end
        end
        w_run: begin
          if (final_xfer) begin
            state <= w_idle;
          end
        end
        default: state <= w_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat and burst counters
  ////////////////////////////////////////////////////////////////////////////
  // Short length loads before the last burst, or at start for a single one
  assign load_beats = (wxfer & wlast & (bursts_left == txn_width'(1))) |
                      (start & plan.single);

  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left  <= '1;
      bursts_left <= '0;
    end else begin
      // Full bursts just wrap from zero to all ones
      if (load_beats) begin
        beats_left <= plan.final_len;
      end else if (wxfer) begin
        beats_left <= beats_left - 1'b1;
      end
      if (start) begin
        bursts_left <= plan.num_bursts;
      end else if (wxfer && wlast) begin
        bursts_left <= bursts_left - 1'b1;
      end
    end
  end

  assign wlast       = (beats_left == '0);
  assign final_burst = (bursts_left == '0);

  // Partial strobe only on the very last beat
  assign w = '{
    data: head,
    strb: (wlast && final_burst) ? plan.final_strb : '1,
    last: wlast
  };

  ////////////////////////////////////////////////////////////////////////////
  // Burst ready pulse
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst      <= 1'b1;
      offer_d1    <= 1'b0;
      pulse_d1    <= 1'b0;
      burst_ready <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      // Cleared on handshake so back-to-back first beats each count
      offer_d1    <= wvalid & wfirst & ~wxfer;
      pulse_d1    <= wvalid & wfirst & ~offer_d1;
      burst_ready <= pulse_d1;
    end
  end

endmodule

// ==== hdl/aw_channel.sv ====
`timescale 1ns/1ps

module aw_channel (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        start,
  input  axi_writer_pkg::burst_plan_t plan,
  input  logic                        burst_ready,
  input  logic                        stall,
  output logic                        awvalid,
  input  logic                        awready,
  output axi_writer_pkg::aw_req_t     aw,
  output logic                        aw_done
);

  import axi_writer_pkg::*;

  // Enough headroom for every burst of a transfer to be waiting
  localparam int pend_width = txn_width + 1;

  logic                  awxfer;
  logic [pend_width-1:0] pending;
  logic [addr_width-1:0] addr;
  logic [txn_width-1:0]  bursts_left;
  logic                  final_aw;

  assign awxfer  = awvalid & awready;
  assign aw_done = awxfer;

  ////////////////////////////////////////////////////////////////////////////
  // Data-waiting count and valid
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      pending <= '0;
    end else if (burst_ready && !awxfer) begin
      pending <= pending + 1'b1;
    end else if (awxfer && !burst_ready) begin
      pending <= pending - 1'b1;
    end
  end

  // An address goes out only once its data is already offered
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if ((pending != '0) && !awvalid && !stall) begin
      awvalid <= 1'b1;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address generator and burst length
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start) begin
      addr <= plan.addr;
    end else if (awxfer) begin
      addr <= addr + addr_width'(burst_bytes);
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      bursts_left <= '0;
    end else if (start) begin
      bursts_left <= plan.num_bursts;
    end else if (awxfer) begin
      bursts_left <= bursts_left - 1'b1;
    end
  end

  // A single burst loads a zero count at start
  assign final_aw = (bursts_left == '0);

  assign aw = '{
    addr: addr,
    len:  final_aw ? plan.final_len : len_width'(burst_beats - 1)
  };

endmodule

// ==== hdl/resp_tracker.sv ====
`timescale 1ns/1ps

module resp_tracker #(
  parameter int max_outstanding = 32
) (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        start,
  input  axi_writer_pkg::burst_plan_t plan,
  input  logic                        aw_done,
  input  logic                        bvalid,
  output logic                        bready,
  output logic                        stall,
  output logic                        done
);

  import axi_writer_pkg::*;

  localparam int vac_width = $clog2(max_outstanding + 1);

  logic                 bxfer;
  logic [vac_width-1:0] vacancy;
  logic [txn_width-1:0] resp_left;

  // Responses are always accepted
  assign bready = 1'b1;
  assign bxfer  = bvalid & bready;

  // Free slots for addresses still awaiting a response
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= vac_width'(max_outstanding);
    end else if (aw_done && !bxfer) begin
      vacancy <= vacancy - 1'b1;
    end else if (bxfer && !aw_done) begin
      vacancy <= vacancy + 1'b1;
    end
  end

  assign stall = (vacancy == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Response countdown and done
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      resp_left <= '0;
      done      <= 1'b0;
    end else begin
      if (start) begin
        resp_left <= plan.num_bursts;
      end else if (bxfer) begin
        resp_left <= resp_left - 1'b1;
      end
      // One cycle after the last response
      done <= bxfer & (resp_left == '0);
    end
  end

endmodule

// ==== hdl/axi_writer.sv ====
`timescale 1ns/1ps

module axi_writer #(
  parameter int max_outstanding = 32,
  parameter int fifo_depth      = 32
) (
  input  logic                                      aclk,
  input  logic                                      areset,
  // Control
  input  logic                                      ctrl_start,
  input  axi_writer_pkg::ctrl_req_t                 ctrl_req,
  output logic                                      ctrl_done,
  // AXI4-Stream slave
  input  logic                                      s_axis_tvalid,
  output logic                                      s_axis_tready,
  input  logic [axi_writer_pkg::data_width-1:0]     s_axis_tdata,
  // AXI4 write address channel
  output logic                                      m_axi_awvalid,
  input  logic                                      m_axi_awready,
  output axi_writer_pkg::aw_req_t                   m_axi_aw,
  // AXI4 write data channel
  output logic                                      m_axi_wvalid,
  input  logic                                      m_axi_wready,
  output axi_writer_pkg::w_beat_t                   m_axi_w,
  // AXI4 write response channel
  input  logic                                      m_axi_bvalid,
  output logic                                      m_axi_bready
);

  import axi_writer_pkg::*;

  // Plan and start pulse fan out to every channel
  burst_plan_t           plan;
  logic                  start;
  // FIFO head towards the data channel
  logic [data_width-1:0] fifo_head;
  logic                  fifo_valid;
  logic                  fifo_pop;
  // Cross-channel events
  logic                  burst_ready;
  logic                  aw_done;
  logic                  stall;

  xfer_setup xfer_setup_inst (
    .aclk       ( aclk       ),
    .areset     ( areset     ),
    .ctrl_start ( ctrl_start ),
    .ctrl_req   ( ctrl_req   ),
    .start      ( start      ),
    .plan       ( plan       )
  );

  stream_fifo #(
    .fifo_depth ( fifo_depth )
  ) stream_fifo_inst (
    .aclk       ( aclk          ),
    .areset     ( areset        ),
    .push_valid ( s_axis_tvalid ),
    .push_ready ( s_axis_tready ),
    .push_data  ( s_axis_tdata  ),
    .pop        ( fifo_pop      ),
    .head       ( fifo_head     ),
    .head_valid ( fifo_valid    )
  );

  // Final burst flag stays internal to the data channel
  w_channel w_channel_inst (
    .aclk        ( aclk         ),
    .areset      ( areset       ),
    .start       ( start        ),
    .plan        ( plan         ),
    .head        ( fifo_head    ),
    .head_valid  ( fifo_valid   ),
    .pop         ( fifo_pop     ),
    .wvalid      ( m_axi_wvalid ),
    .wready      ( m_axi_wready ),
    .w           ( m_axi_w      ),
    .burst_ready ( burst_ready  ),
    .final_burst (              )
  );

  aw_channel aw_channel_inst (
    .aclk        ( aclk          ),
    .areset      ( areset        ),
    .start       ( start         ),
    .plan        ( plan          ),
    .burst_ready ( burst_ready   ),
    .stall       ( stall         ),
    .awvalid     ( m_axi_awvalid ),
    .awready     ( m_axi_awready ),
    .aw          ( m_axi_aw      ),
    .aw_done     ( aw_done       )
  );

  resp_tracker #(
    .max_outstanding ( max_outstanding )
  ) resp_tracker_inst (
    .aclk    ( aclk         ),
    .areset  ( areset       ),
    .start   ( start        ),
    .plan    ( plan         ),
    .aw_done ( aw_done      ),
    .bvalid  ( m_axi_bvalid ),
    .bready  ( m_axi_bready ),
    .stall   ( stall        ),
    .done    ( ctrl_done    )
  );

endmodule

// ==== verification/tb_axi_writer.sv ====
`timescale 1ns/1ps

module tb_axi_writer;

  import axi_writer_pkg::*;

  // Cycle budget for any single wait
  localparam int wait_limit = 40000;
  localparam int fifo_words = 32;

  logic                  aclk;
  logic                  areset;
  logic                  ctrl_start;
  ctrl_req_t             ctrl_req;
  logic                  ctrl_done;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic [data_width-1:0] s_axis_tdata;
  logic                  m_axi_awvalid;
  logic                  m_axi_awready;
  aw_req_t               m_axi_aw;
  logic                  m_axi_wvalid;
  logic                  m_axi_wready;
  w_beat_t               m_axi_w;
  logic                  m_axi_bvalid;
  logic                  m_axi_bready;

  integer seed = 32'h4858_b790;

  // Reference traffic in issue order
  aw_req_t     exp_aw[$];
  w_beat_t     exp_w[$];
  logic [31:0] stream_q[$];

  // Handshake bookkeeping accumulated over the run
  int aw_count         = 0;
  int wlast_count      = 0;
  int resp_count       = 0;
  int resp_expected    = 0;
  int b_issued         = 0;
  int done_count       = 0;
  int xfers_started    = 0;
  int cycle            = 0;
  int last_b_cycle     = -10;
  int peak_outstanding = 0;
  // Words held in the data FIFO by the stream and write handshakes
  int fifo_fill        = 0;

  // Slave and source behavior
  int aw_pct  = 100;
  int w_pct   = 100;
  int gap_pct = 0;
  int b_min   = 0;
  int b_max   = 2;
  int b_delay = -1;

  string test_name = "reset";
  int    errors          = 0;
  int    errors_at_start = 0;
  int    tests_run       = 0;
  int    tests_failed    = 0;

  axi_writer #(
    .max_outstanding ( 2          ),
    .fifo_depth      ( fifo_words )
  ) axi_writer_inst (
    .aclk          ( aclk          ),
    .areset        ( areset        ),
    .ctrl_start    ( ctrl_start    ),
    .ctrl_req      ( ctrl_req      ),
    .ctrl_done     ( ctrl_done     ),
    .s_axis_tvalid ( s_axis_tvalid ),
    .s_axis_tready ( s_axis_tready ),
    .s_axis_tdata  ( s_axis_tdata  ),
    .m_axi_awvalid ( m_axi_awvalid ),
    .m_axi_awready ( m_axi_awready ),
    .m_axi_aw      ( m_axi_aw      ),
    .m_axi_wvalid  ( m_axi_wvalid  ),
    .m_axi_wready  ( m_axi_wready  ),
    .m_axi_w       ( m_axi_w       ),
    .m_axi_bvalid  ( m_axi_bvalid  ),
    .m_axi_bready  ( m_axi_bready  )
  );

  always #20 aclk = ~aclk;

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor sampling every handshake on the rising edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge aclk) begin : bus_monitor
    aw_req_t want_aw;
    w_beat_t want_w;
    cycle++;
    // Done must trail the last response by exactly one cycle
    if (ctrl_done) begin
      done_count++;
      assert (resp_count == resp_expected) else begin
        errors++;
        $display("Fail %s: responses at done expected %0d actual %0d",
                 test_name, resp_expected, resp_count);
      end
      assert (last_b_cycle == cycle - 1) else begin
        errors++;
        $display("In %s ctrl_done did not come one cycle after the final response", test_name);
      end
      assert (done_count <= xfers_started) else begin
        errors++;
        $display("In %s ctrl_done pulsed with no transfer running", test_name);
      end
    end
    // Ready outputs against the FIFO fill model
    if (!areset) begin
      assert (s_axis_tready == (fifo_fill < fifo_words - 1)) else begin
        errors++;
        $display("Fail %s: s_axis_tready expected %b actual %b", test_name,
                 fifo_fill < fifo_words - 1, s_axis_tready);
      end
      assert (m_axi_bready) else begin
        errors++;
        $display("In %s m_axi_bready dropped low", test_name);
      end
    end
    if (s_axis_tvalid && s_axis_tready) begin
      fifo_fill++;
    end
    if (m_axi_awvalid && m_axi_awready) begin
      aw_count++;
      assert (exp_aw.size() > 0) else begin
        errors++;
        $display("In %s an address beat arrived that no burst needs", test_name);
      end
      if (exp_aw.size() > 0) begin
        want_aw = exp_aw.pop_front();
        assert (m_axi_aw == want_aw) else begin
          errors++;
          $display("Fail %s: aw expected addr %h len %0d actual addr %h len %0d", test_name,
                   want_aw.addr, want_aw.len, m_axi_aw.addr, m_axi_aw.len);
        end
      end
    end
    if (m_axi_wvalid && m_axi_wready) begin
      fifo_fill--;
      if (m_axi_w.last) begin
        wlast_count++;
      end
      assert (exp_w.size() > 0) else begin
        errors++;
        $display("In %s a data beat arrived beyond the expected stream", test_name);
      end
      if (exp_w.size() > 0) begin
        want_w = exp_w.pop_front();
        assert (m_axi_w == want_w) else begin
          errors++;
          $display("Fail %s: w expected %h/%h/%b actual %h/%h/%b", test_name,
                   want_w.data, want_w.strb, want_w.last,
                   m_axi_w.data, m_axi_w.strb, m_axi_w.last);
        end
      end
    end
    if (m_axi_bvalid && m_axi_bready) begin
      resp_count++;
      last_b_cycle = cycle;
    end
    // Outstanding addresses stay within the cap of two
    if (aw_count - resp_count > peak_outstanding) begin
      peak_outstanding = aw_count - resp_count;
    end
    assert (aw_count - resp_count <= 2) else begin
      errors++;
      $display("In %s more than two address beats are waiting for a response", test_name);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream source and AXI slave driven 2 ns after the edge
  ////////////////////////////////////////////////////////////////////////////
  always begin : slave_driver
    logic s_hs;
    logic b_hs;
    @(posedge aclk);
    s_hs = s_axis_tvalid & s_axis_tready;
    b_hs = m_axi_bvalid & m_axi_bready;
    #2;
    m_axi_awready = (rand_range(0, 99) < aw_pct);
    m_axi_wready  = (rand_range(0, 99) < w_pct);
    if (s_hs) begin
      s_axis_tvalid = 1'b0;
    end
    // Random gaps between stream words
    if (!s_axis_tvalid && stream_q.size() > 0 && rand_range(0, 99) >= gap_pct) begin
      s_axis_tdata  = stream_q.pop_front();
      s_axis_tvalid = 1'b1;
    end
    if (b_hs) begin
      m_axi_bvalid = 1'b0;
    end
    // Response only once address and all data of that burst are in
    if (!m_axi_bvalid && b_issued < aw_count && b_issued < wlast_count) begin
      if (b_delay < 0) begin
        b_delay = rand_range(b_min, b_max);
      end else if (b_delay == 0) begin
        m_axi_bvalid = 1'b1;
        b_issued++;
        b_delay = -1;
      end else begin
        b_delay--;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test tasks
  ////////////////////////////////////////////////////////////////////////////
  task automatic fail_on_timeout(input string what);
    $display("Timeout in %s while waiting for %s", test_name, what);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic set_pressure(input int aw, input int w, input int gap,
                              input int bmin, input int bmax);
    aw_pct  = aw;
    w_pct   = w;
    gap_pct = gap;
    b_min   = bmin;
    b_max   = bmax;
  endtask

  // Builds the expected bursts, queues the stream words, pulses start
  task automatic start_transfer(input logic [31:0] addr, input int size);
    int         total_len;
    int         last_burst;
    int         len;
    int         rem;
    logic [3:0] last_strb;
    aw_req_t    a;
    w_beat_t    b;
    @(posedge aclk);
    #1;
    total_len  = (size + 3) / 4 - 1;
    last_burst = total_len / 256;
    rem        = size % 4;
    // Whole last beat uses all four lanes
    last_strb  = (rem == 0) ? 4'hf : 4'((1 << rem) - 1);
    for (int k = 0; k <= last_burst; k++) begin
      len    = (k == last_burst) ? total_len % 256 : 255;
      a.addr = (addr & 32'hffff_f000) + 32'(k * 4096);
      a.len  = 8'(len);
      exp_aw.push_back(a);
      for (int j = 0; j <= len; j++) begin
        b.data = $random(seed);
        b.strb = (k == last_burst && j == len) ? last_strb : 4'hf;
        b.last = (j == len);
        exp_w.push_back(b);
        stream_q.push_back(b.data);
      end
    end
    resp_expected += last_burst + 1;
    xfers_started++;
    #1;
    ctrl_req.addr = addr;
    ctrl_req.size = 20'(size);
    ctrl_start    = 1'b1;
    @(posedge aclk);
    #2;
    ctrl_start = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done_count < xfers_started) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > wait_limit) begin
        fail_on_timeout("ctrl_done");
      end
    end
  endtask

  task automatic run_transfer(input logic [31:0] addr, input int size);
    start_transfer(addr, size);
    wait_done();
  endtask

  task automatic begin_test(input string name);
    test_name        = name;
    errors_at_start  = errors;
    peak_outstanding = 0;
  endtask

  task automatic end_test();
    // Short idle to catch a stray done or extra beat
    repeat (8) @(posedge aclk);
    #1;
    assert (exp_aw.size() == 0) else begin
      errors++;
      $display("Fail %s: address beats left expected 0 actual %0d", test_name, exp_aw.size());
    end
    assert (exp_w.size() == 0) else begin
      errors++;
      $display("Fail %s: data beats left expected 0 actual %0d", test_name, exp_w.size());
    end
    assert (done_count == xfers_started) else begin
      errors++;
      $display("Fail %s: done pulses expected %0d actual %0d",
               test_name, xfers_started, done_count);
    end
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
    end
    $display("Test %s %s", test_name, (errors == errors_at_start) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin : main_sequence
    logic [31:0] addr;
    int          size;
    aclk          = 1'b0;
    areset        = 1'b1;
    ctrl_start    = 1'b0;
    ctrl_req      = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    repeat (16) @(posedge aclk);
    #2;
    areset = 1'b0;

    // Sub-beat up to one full burst
    begin_test("single_burst");
    run_transfer(32'h0000_3000, 1);
    run_transfer(32'h0000_5000, 2);
    run_transfer(32'h0002_0000, 3);
    run_transfer(32'h0004_7000, 6);
    run_transfer(32'h0010_0000, 1021);
    run_transfer(32'h0011_0000, 1024);
    end_test();

    // One-beat tail, full tail and the largest count
    begin_test("multi_burst");
    run_transfer(32'h0001_0000, 4097);
    run_transfer(32'h0020_0000, 8192);
    run_transfer(32'h0030_0000, 9000);
    end_test();

    begin_test("unaligned_addr");
    run_transfer(32'h0000_1234, 5000);
    addr = $random(seed);
    addr = addr | 32'h1;
    size = rand_range(1, 9000);
    run_transfer(addr, size);
    end_test();

    begin_test("random_backpressure");
    set_pressure(60, 55, 40, 0, 6);
    for (int i = 0; i < 4; i++) begin
      addr = $random(seed);
      size = rand_range(1, 9000);
      run_transfer(addr, size);
    end
    end_test();

    // Slow responses drive the vacancy count to zero
    begin_test("held_responses");
    set_pressure(80, 90, 10, 40, 80);
    run_transfer(32'h8000_0000, 9000);
    assert (peak_outstanding == 2) else begin
      errors++;
      $display("Fail %s: peak outstanding expected 2 actual %0d", test_name, peak_outstanding);
    end
    end_test();

    begin_test("back_to_back");
    set_pressure(75, 75, 20, 0, 4);
    for (int i = 0; i < 5; i++) begin
      addr = $random(seed);
      size = rand_range(1, 6000);
      run_transfer(addr, size);
    end
    end_test();

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== axi_writer.f ====
hdl/axi_writer_pkg.sv
hdl/xfer_setup.sv
hdl/stream_fifo.sv
hdl/w_channel.sv
hdl/aw_channel.sv
hdl/resp_tracker.sv
hdl/axi_writer.sv
verification/tb_axi_writer.sv

// ==== Bender.yml ====
package:
  name: axi_writer

sources:
  - hdl/axi_writer_pkg.sv
  - hdl/xfer_setup.sv
  - hdl/stream_fifo.sv
  - hdl/w_channel.sv
  - hdl/aw_channel.sv
  - hdl/resp_tracker.sv
  - hdl/axi_writer.sv
  - target: test
    files:
      - verification/tb_axi_writer.sv
